//--- mem_issue_pkg.sv
package mem_issue_pkg;

    localparam int IQ_DEPTH        = 8;
    localparam int PORT_NUM        = 2;
    localparam int EXT_WB_NUM      = 2;
    localparam int STORE_ISSUE_NUM = 2;
    localparam int PREG_NUM        = 32;
    localparam int ROB_SIZE        = 64;
    localparam int BANK_NUM        = 4;

    typedef logic [$clog2(PREG_NUM)-1:0] preg_idx_t;
    typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;
    typedef logic [$clog2(IQ_DEPTH)-1:0] iq_idx_t;
    typedef logic [$clog2(BANK_NUM)-1:0] bank_t;

    // only LOAD writes a destination register
    typedef enum logic [1:0] {
        LOAD,
        STORE_ADDR,
        PREFETCH
    } mem_op_e;

    typedef struct packed {
        mem_op_e   op;
        rob_idx_t  rob_idx;
        preg_idx_t prs_idx;
        preg_idx_t prd_idx;
        logic      rd_wen;
        // rob index of the store this op waits for
        rob_idx_t  dep_rob_idx;
        logic      has_memdep;
        bank_t     bank;
    } mem_uop_t;

    // outcome of the execute stage
    typedef enum logic [1:0] {
        NONE,
        DONE,
        REPLAY
    } pipe_state_e;

endpackage

//--- mem_issue_if.sv
// dispatch side into the issue queue
interface iq_enq_if import mem_issue_pkg::*; ();
    logic [PORT_NUM-1:0] enq_vld;
    mem_uop_t            enq_uop [PORT_NUM];
    logic [PORT_NUM-1:0] enq_src_rdy;
    logic [PORT_NUM-1:0] enq_memdep_rdy;
    // at least PORT_NUM free entries
    logic                can_enq;

    modport src (
        output enq_vld, enq_uop, enq_src_rdy, enq_memdep_rdy,
        input  can_enq
    );
    modport dst (
        input  enq_vld, enq_uop, enq_src_rdy, enq_memdep_rdy,
        output can_enq
    );
endinterface

// issue out of the queue and feedback from the execute stage
interface iq_issue_if import mem_issue_pkg::*; ();
    logic [PORT_NUM-1:0] can_issue;
    iq_idx_t             issue_idx [PORT_NUM];
    mem_uop_t            issue_uop [PORT_NUM];
    logic [PORT_NUM-1:0] pipe_busy;
    // one-cycle pulses, never both on one port
    logic [PORT_NUM-1:0] fin_vec;
    logic [PORT_NUM-1:0] replay_vec;
    iq_idx_t             fb_idx [PORT_NUM];

    modport q (
        output can_issue, issue_idx, issue_uop,
        input  pipe_busy, fin_vec, replay_vec, fb_idx
    );
    modport p (
        input  can_issue, issue_idx, issue_uop,
        output pipe_busy, fin_vec, replay_vec, fb_idx
    );
endinterface

//--- mem_dispatch_stage.sv
module mem_dispatch_stage import mem_issue_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [PORT_NUM-1:0]        i_disp_vld,
    input  mem_uop_t                   i_disp_uop [PORT_NUM],
    output logic                       o_disp_ready,
    input  logic [PORT_NUM-1:0]        i_wb_vld,
    input  preg_idx_t                  i_wb_prd [PORT_NUM],
    input  logic [EXT_WB_NUM-1:0]      i_ext_wb_vld,
    input  preg_idx_t                  i_ext_wb_prd [EXT_WB_NUM],
    input  logic [STORE_ISSUE_NUM-1:0] i_store_issue,
    input  rob_idx_t                   i_store_rob_idx [STORE_ISSUE_NUM],
    iq_enq_if.src                      enq,
    output logic [PREG_NUM-1:0]        o_preg_rdy
);

    logic [PORT_NUM-1:0] hold_vld;
    mem_uop_t            hold_uop [PORT_NUM];
    logic [PREG_NUM-1:0] preg_busy;
    logic [PREG_NUM-1:0] wb_hit;

    // all writebacks of this cycle, own pipe and other clusters
    always_comb begin
        wb_hit = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            if (i_wb_vld[p])
                wb_hit[i_wb_prd[p]] = 1'b1;
        end
        for (int w = 0; w < EXT_WB_NUM; w++) begin
            if (i_ext_wb_vld[w])
                wb_hit[i_ext_wb_prd[w]] = 1'b1;
        end
    end

    // a held group blocks new dispatch until the queue takes it
    assign o_disp_ready = ~|hold_vld | enq.can_enq;
    assign o_preg_rdy   = ~preg_busy;
    assign enq.enq_vld  = hold_vld;
    assign enq.enq_uop  = hold_uop;

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            // a same-cycle writeback counts as ready
            enq.enq_src_rdy[p] = !preg_busy[hold_uop[p].prs_idx] ||
                                 wb_hit[hold_uop[p].prs_idx];
            enq.enq_memdep_rdy[p] = !hold_uop[p].has_memdep;
            for (int s = 0; s < STORE_ISSUE_NUM; s++) begin
                if (i_store_issue[s] && i_store_rob_idx[s] == hold_uop[p].dep_rob_idx)
                    enq.enq_memdep_rdy[p] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_vld  <= '0;
            preg_busy <= '0;
        end else begin
            preg_busy <= preg_busy & ~wb_hit;
            if (o_disp_ready) begin
                hold_vld <= i_disp_vld;
                // new load destinations go busy
                for (int p = 0; p < PORT_NUM; p++) begin
                    if (i_disp_vld[p] && i_disp_uop[p].op == LOAD && i_disp_uop[p].rd_wen)
                        preg_busy[i_disp_uop[p].prd_idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_disp_ready)
            hold_uop <= i_disp_uop;
    end

endmodule

//--- age_select.sv
module age_select import mem_issue_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [IQ_DEPTH-1:0] i_vld,
    input  rob_idx_t            i_ages [IQ_DEPTH],
    output logic [PORT_NUM-1:0] o_vld,
    output iq_idx_t             o_sel_idx [PORT_NUM]
);

    // oldest rob index picked so far, base for the wraparound compare
    rob_idx_t head;
    rob_idx_t rel [IQ_DEPTH];
    rob_idx_t head_step;

    always_comb begin
        logic [IQ_DEPTH-1:0] cand;
        rob_idx_t            best;
        cand = i_vld;
        best = '1;
        for (int e = 0; e < IQ_DEPTH; e++) begin
            rel[e] = i_ages[e] - head;
        end
        // port 0 takes the oldest, port 1 the next oldest
        for (int p = 0; p < PORT_NUM; p++) begin
            o_vld[p]     = 1'b0;
            o_sel_idx[p] = '0;
            best         = '1;
            for (int e = 0; e < IQ_DEPTH; e++) begin
                if (cand[e] && (!o_vld[p] || rel[e] < best)) begin
                    o_vld[p]     = 1'b1;
                    o_sel_idx[p] = iq_idx_t'(e);
                    best         = rel[e];
                end
            end
            if (o_vld[p])
                cand[o_sel_idx[p]] = 1'b0;
        end
    end

    assign head_step = i_ages[o_sel_idx[0]] - head;

    // head only moves forward within half the rob
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else if (o_vld[0] && head_step < rob_idx_t'(ROB_SIZE / 2)) begin
            head <= i_ages[o_sel_idx[0]];
        end
    end

endmodule

//--- mem_issue_queue.sv
module mem_issue_queue import mem_issue_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    iq_enq_if.dst                      enq,
    iq_issue_if.q                      iss,
    output logic [PORT_NUM-1:0]        o_spec_wk_vld,
    output preg_idx_t                  o_spec_wk_prd [PORT_NUM],
    input  logic [PORT_NUM-1:0]        i_spec_wk_vld,
    input  preg_idx_t                  i_spec_wk_prd [PORT_NUM],
    input  logic [PORT_NUM-1:0]        i_wb_vld,
    input  preg_idx_t                  i_wb_prd [PORT_NUM],
    input  logic [EXT_WB_NUM-1:0]      i_ext_wb_vld,
    input  preg_idx_t                  i_ext_wb_prd [EXT_WB_NUM],
    input  logic [STORE_ISSUE_NUM-1:0] i_store_issue,
    input  rob_idx_t                   i_store_rob_idx [STORE_ISSUE_NUM]
);

    // entry state
    logic [IQ_DEPTH-1:0] ent_vld;
    logic [IQ_DEPTH-1:0] ent_issued;
    logic [IQ_DEPTH-1:0] ent_memdep_rdy;
    logic [IQ_DEPTH-1:0] ent_src_rdy;
    logic [IQ_DEPTH-1:0] ent_spec_rdy;
    mem_uop_t            ent_uop [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] nxt_memdep_rdy;
    logic [IQ_DEPTH-1:0] nxt_src_rdy;
    logic [IQ_DEPTH-1:0] nxt_spec_rdy;
    logic [IQ_DEPTH-1:0] entry_ready;
    rob_idx_t            ages [IQ_DEPTH];

    logic [PORT_NUM-1:0] free_found;
    iq_idx_t             free_idx [PORT_NUM];
    logic [PORT_NUM-1:0] enq_fire;
    logic [PORT_NUM-1:0] sel_vld;
    iq_idx_t             sel_idx [PORT_NUM];
    logic [PORT_NUM-1:0] can_issue_q;
    iq_idx_t             issue_idx_q [PORT_NUM];

    // lowest free entries, one per dispatch slot
    always_comb begin
        logic [IQ_DEPTH-1:0] taken;
        taken = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            free_found[p] = 1'b0;
            free_idx[p]   = '0;
            for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
                if (!ent_vld[e] && !taken[e]) begin
                    free_found[p] = 1'b1;
                    free_idx[p]   = iq_idx_t'(e);
                end
            end
            if (free_found[p])
                taken[free_idx[p]] = 1'b1;
        end
    end

    assign enq.can_enq = &free_found;
    assign enq_fire    = enq.enq_vld & {PORT_NUM{enq.can_enq}};

    // wakeup from writebacks, speculative wakeups and store issue
    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            nxt_src_rdy[e]    = ent_src_rdy[e];
            nxt_spec_rdy[e]   = ent_spec_rdy[e];
            nxt_memdep_rdy[e] = ent_memdep_rdy[e];
            for (int p = 0; p < PORT_NUM; p++) begin
                if (i_wb_vld[p] && i_wb_prd[p] == ent_uop[e].prs_idx)
                    nxt_src_rdy[e] = 1'b1;
                if (i_spec_wk_vld[p] && i_spec_wk_prd[p] == ent_uop[e].prs_idx)
                    nxt_spec_rdy[e] = 1'b1;
            end
            for (int w = 0; w < EXT_WB_NUM; w++) begin
                if (i_ext_wb_vld[w] && i_ext_wb_prd[w] == ent_uop[e].prs_idx)
                    nxt_src_rdy[e] = 1'b1;
            end
            for (int s = 0; s < STORE_ISSUE_NUM; s++) begin
                if (i_store_issue[s] && i_store_rob_idx[s] == ent_uop[e].dep_rob_idx)
                    nxt_memdep_rdy[e] = 1'b1;
            end
            entry_ready[e] = ent_vld[e] && !ent_issued[e] && ent_memdep_rdy[e] &&
                             (ent_src_rdy[e] || ent_spec_rdy[e]);
            ages[e] = ent_uop[e].rob_idx;
        end
    end

    age_select u_age_select (
        .clk       (clk),
        .rst       (rst),
        .i_vld     (entry_ready),
        .i_ages    (ages),
        .o_vld     (sel_vld),
        .o_sel_idx (sel_idx)
    );

    // loads wake their consumers as soon as they are picked
    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            o_spec_wk_vld[p] = sel_vld[p] && !iss.pipe_busy[p] &&
                               ent_uop[sel_idx[p]].op == LOAD && ent_uop[sel_idx[p]].rd_wen;
            o_spec_wk_prd[p] = ent_uop[sel_idx[p]].prd_idx;
            iss.issue_uop[p] = ent_uop[issue_idx_q[p]];
        end
    end

    assign iss.can_issue = can_issue_q;
    assign iss.issue_idx = issue_idx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld     <= '0;
            can_issue_q <= '0;
        end else begin
            ent_src_rdy    <= nxt_src_rdy;
            ent_spec_rdy   <= nxt_spec_rdy;
            ent_memdep_rdy <= nxt_memdep_rdy;
            for (int p = 0; p < PORT_NUM; p++) begin
                // selection holds while the pipe is busy
                if (!iss.pipe_busy[p]) begin
                    can_issue_q[p] <= sel_vld[p];
                    issue_idx_q[p] <= sel_idx[p];
                    if (sel_vld[p])
                        ent_issued[sel_idx[p]] <= 1'b1;
                end
                if (iss.fin_vec[p]) begin
                    ent_vld[iss.fb_idx[p]] <= 1'b0;
                end else if (iss.replay_vec[p]) begin
                    // drop the speculative readiness, keep what is real
                    ent_issued[iss.fb_idx[p]]   <= 1'b0;
                    ent_spec_rdy[iss.fb_idx[p]] <= nxt_src_rdy[iss.fb_idx[p]];
                end
                if (enq_fire[p]) begin
                    ent_vld[free_idx[p]]        <= 1'b1;
                    ent_issued[free_idx[p]]     <= 1'b0;
                    ent_uop[free_idx[p]]        <= enq.enq_uop[p];
                    ent_memdep_rdy[free_idx[p]] <= enq.enq_memdep_rdy[p];
                    ent_src_rdy[free_idx[p]]    <= enq.enq_src_rdy[p];
                    ent_spec_rdy[free_idx[p]]   <= enq.enq_src_rdy[p];
                end
            end
        end
    end

endmodule

//--- mem_issue_pipe.sv
module mem_issue_pipe import mem_issue_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    iq_issue_if.p               iss,
    input  logic [PREG_NUM-1:0] i_preg_rdy,
    output logic [PORT_NUM-1:0] o_done_vld,
    output rob_idx_t            o_done_rob_idx [PORT_NUM],
    output logic [PORT_NUM-1:0] o_wb_vld,
    output preg_idx_t           o_wb_prd [PORT_NUM]
);

    // register read stage
    logic [PORT_NUM-1:0] rr_vld;
    mem_uop_t            rr_uop [PORT_NUM];
    iq_idx_t             rr_idx [PORT_NUM];
    pipe_state_e         ex_state [PORT_NUM];

    // no stall source in this pipe
    assign iss.pipe_busy = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_vld <= '0;
        end else begin
            rr_vld <= iss.can_issue;
        end
    end

    always_ff @(posedge clk) begin
        rr_uop <= iss.issue_uop;
        rr_idx <= iss.issue_idx;
    end

    // execute stage, decide done or replay
    always_comb begin
        logic bank_clash;
        bank_clash = 1'b0;
        for (int p = 0; p < PORT_NUM; p++) begin
            bank_clash = 1'b0;
            // a lower port wins the bank
            for (int q = 0; q < p; q++) begin
                if (rr_vld[q] && rr_uop[q].bank == rr_uop[p].bank)
                    bank_clash = 1'b1;
            end
            if (!rr_vld[p])
                ex_state[p] = NONE;
            else if (bank_clash || !i_preg_rdy[rr_uop[p].prs_idx])
                ex_state[p] = REPLAY;
            else
                ex_state[p] = DONE;

            o_done_vld[p]     = ex_state[p] == DONE;
            o_done_rob_idx[p] = rr_uop[p].rob_idx;
            o_wb_vld[p]       = ex_state[p] == DONE && rr_uop[p].op == LOAD &&
                                rr_uop[p].rd_wen;
            o_wb_prd[p]       = rr_uop[p].prd_idx;

            iss.fin_vec[p]    = ex_state[p] == DONE;
            iss.replay_vec[p] = ex_state[p] == REPLAY;
            iss.fb_idx[p]     = rr_idx[p];
        end
    end

endmodule

//--- mem_issue_top.sv
module mem_issue_top import mem_issue_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [PORT_NUM-1:0]        i_disp_vld,
    input  mem_uop_t                   i_disp_uop [PORT_NUM],
    input  logic [EXT_WB_NUM-1:0]      i_ext_wb_vld,
    input  preg_idx_t                  i_ext_wb_prd [EXT_WB_NUM],
    input  logic [STORE_ISSUE_NUM-1:0] i_store_issue,
    input  rob_idx_t                   i_store_rob_idx [STORE_ISSUE_NUM],
    output logic                       o_disp_ready,
    output logic [PORT_NUM-1:0]        o_done_vld,
    output rob_idx_t                   o_done_rob_idx [PORT_NUM],
    output logic [PORT_NUM-1:0]        o_wb_vld,
    output preg_idx_t                  o_wb_prd [PORT_NUM]
);

    iq_enq_if   enq_if ();
    iq_issue_if iss_if ();

    // speculative wakeup loop of the queue
    logic [PORT_NUM-1:0] spec_wk_vld;
    preg_idx_t           spec_wk_prd [PORT_NUM];
    logic [PREG_NUM-1:0] preg_rdy;

    mem_dispatch_stage u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .i_disp_vld      (i_disp_vld),
        .i_disp_uop      (i_disp_uop),
        .o_disp_ready    (o_disp_ready),
        .i_wb_vld        (o_wb_vld),
        .i_wb_prd        (o_wb_prd),
        .i_ext_wb_vld    (i_ext_wb_vld),
        .i_ext_wb_prd    (i_ext_wb_prd),
        .i_store_issue   (i_store_issue),
        .i_store_rob_idx (i_store_rob_idx),
        .enq             (enq_if),
        .o_preg_rdy      (preg_rdy)
    );

    mem_issue_queue u_queue (
        .clk             (clk),
        .rst             (rst),
        .enq             (enq_if),
        .iss             (iss_if),
        .o_spec_wk_vld   (spec_wk_vld),
        .o_spec_wk_prd   (spec_wk_prd),
        .i_spec_wk_vld   (spec_wk_vld),
        .i_spec_wk_prd   (spec_wk_prd),
        .i_wb_vld        (o_wb_vld),
        .i_wb_prd        (o_wb_prd),
        .i_ext_wb_vld    (i_ext_wb_vld),
        .i_ext_wb_prd    (i_ext_wb_prd),
        .i_store_issue   (i_store_issue),
        .i_store_rob_idx (i_store_rob_idx)
    );

    mem_issue_pipe u_pipe (
        .clk            (clk),
        .rst            (rst),
        .iss            (iss_if),
        .i_preg_rdy     (preg_rdy),
        .o_done_vld     (o_done_vld),
        .o_done_rob_idx (o_done_rob_idx),
        .o_wb_vld       (o_wb_vld),
        .o_wb_prd       (o_wb_prd)
    );

endmodule

//--- mem_issue_props.sv
module mem_issue_props import mem_issue_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic [IQ_DEPTH-1:0] ent_vld,
    input logic [PORT_NUM-1:0] enq_fire,
    input iq_idx_t             free_idx [PORT_NUM],
    input logic [PORT_NUM-1:0] fin_vec,
    input logic [PORT_NUM-1:0] replay_vec,
    input iq_idx_t             fb_idx [PORT_NUM]
);

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        // enqueue only into a free entry
        a_enq_free: assert property (@(posedge clk) disable iff (rst)
            enq_fire[p] |-> !ent_vld[free_idx[p]])
            else $error("enqueue into a valid entry on port %0d", p);

        a_fb_excl: assert property (@(posedge clk) disable iff (rst)
            !(fin_vec[p] && replay_vec[p]))
            else $error("finish and replay together on port %0d", p);

        // feedback must land on a live entry
        a_fb_live: assert property (@(posedge clk) disable iff (rst)
            (fin_vec[p] || replay_vec[p]) |-> ent_vld[fb_idx[p]])
            else $error("feedback to an empty entry on port %0d", p);
    end

endmodule

bind mem_issue_queue mem_issue_props u_props (
    .clk        (clk),
    .rst        (rst),
    .ent_vld    (ent_vld),
    .enq_fire   (enq_fire),
    .free_idx   (free_idx),
    .fin_vec    (iss.fin_vec),
    .replay_vec (iss.replay_vec),
    .fb_idx     (iss.fb_idx)
);

//--- mem_issue_tb.sv
module mem_issue_tb import mem_issue_pkg::*; ();

    localparam int N_OPS   = 300;
    localparam int TIMEOUT = N_OPS * IQ_DEPTH * 20;

    logic                       clk;
    logic                       rst;
    logic [PORT_NUM-1:0]        disp_vld;
    mem_uop_t                   disp_uop [PORT_NUM];
    logic [EXT_WB_NUM-1:0]      ext_wb_vld;
    preg_idx_t                  ext_wb_prd [EXT_WB_NUM];
    logic [STORE_ISSUE_NUM-1:0] store_issue;
    rob_idx_t                   store_rob [STORE_ISSUE_NUM];
    logic                       disp_ready;
    logic [PORT_NUM-1:0]        done_vld;
    rob_idx_t                   done_rob [PORT_NUM];
    logic [PORT_NUM-1:0]        wb_vld;
    preg_idx_t                  wb_prd [PORT_NUM];

    // reference model, per rob index and per physical register
    bit       out_q [ROB_SIZE];
    mem_uop_t exp_uop [ROB_SIZE];
    bit       dep_seen [ROB_SIZE];
    bit       waits [ROB_SIZE];
    int       disp_cyc [ROB_SIZE];
    bit       allocated [PREG_NUM];
    bit       pending_ld [PREG_NUM];
    // load that owns each destination register
    rob_idx_t ld_rob [PREG_NUM];
    int       readers [PREG_NUM];
    int       last_wb [PREG_NUM];
    int       cycle;
    int       n_sent;
    int       n_out;
    rob_idx_t next_rob;

    mem_issue_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .i_disp_vld      (disp_vld),
        .i_disp_uop      (disp_uop),
        .i_ext_wb_vld    (ext_wb_vld),
        .i_ext_wb_prd    (ext_wb_prd),
        .i_store_issue   (store_issue),
        .i_store_rob_idx (store_rob),
        .o_disp_ready    (disp_ready),
        .o_done_vld      (done_vld),
        .o_done_rob_idx  (done_rob),
        .o_wb_vld        (wb_vld),
        .o_wb_prd        (wb_prd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_rob(input string name, input rob_idx_t exp, input rob_idx_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "rob index mismatch");
        end
    endtask

    task automatic compare_preg(input string name, input preg_idx_t exp, input preg_idx_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "preg index mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // a register goes back to the pool once written and no longer read
    task automatic release_preg(input preg_idx_t r);
        if (allocated[r] && !pending_ld[r] && readers[r] == 0)
            allocated[r] = 1'b0;
    endtask

    task automatic check_outputs();
        rob_idx_t r;
        mem_uop_t u;
        // queue plus dispatch register full
        if (n_out >= IQ_DEPTH + PORT_NUM)
            compare_flag("o_disp_ready", 1'b0, disp_ready);
        for (int p = 0; p < PORT_NUM; p++) begin
            if (done_vld[p])
                compare_flag("o_done_vld rob outstanding", 1'b1, out_q[done_rob[p]]);
            else
                compare_flag("o_wb_vld", 1'b0, wb_vld[p]);
        end
        if (&done_vld)
            compare_flag("same bank completion", 1'b0,
                         exp_uop[done_rob[0]].bank == exp_uop[done_rob[1]].bank);
        for (int p = 0; p < PORT_NUM; p++) begin
            if (done_vld[p] && wb_vld[p])
                last_wb[wb_prd[p]] = cycle;
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            if (done_vld[p]) begin
                r = done_rob[p];
                u = exp_uop[r];
                if (u.has_memdep)
                    compare_flag("store issue before done", 1'b1, dep_seen[r]);
                if (waits[r])
                    compare_flag("source written back", 1'b1,
                                 last_wb[u.prs_idx] > disp_cyc[r] && last_wb[u.prs_idx] < cycle);
                compare_flag("o_wb_vld", u.op == LOAD && u.rd_wen, wb_vld[p]);
                if (wb_vld[p]) begin
                    compare_rob("o_done_rob_idx", ld_rob[wb_prd[p]], done_rob[p]);
                    compare_preg("o_wb_prd", u.prd_idx, wb_prd[p]);
                end
                out_q[r] = 1'b0;
                n_out--;
                readers[u.prs_idx]--;
                release_preg(u.prs_idx);
                if (u.op == LOAD && u.rd_wen) begin
                    pending_ld[u.prd_idx] = 1'b0;
                    release_preg(u.prd_idx);
                end
            end
        end
    endtask

    function automatic mem_uop_t build_uop();
        mem_uop_t u;
        int       k;
        int       s;
        k        = $urandom_range(9);
        u.op     = k < 6 ? LOAD : (k < 8 ? STORE_ADDR : PREFETCH);
        u.rob_idx = next_rob;
        u.prs_idx = preg_idx_t'($urandom_range(PREG_NUM - 1));
        // mostly read an earlier destination
        if ($urandom_range(3) != 0) begin
            s = $urandom_range(PREG_NUM - 1);
            for (int i = 0; i < PREG_NUM; i++) begin
                if (allocated[(s + i) % PREG_NUM]) begin
                    u.prs_idx = preg_idx_t'((s + i) % PREG_NUM);
                    break;
                end
            end
        end
        u.prd_idx = preg_idx_t'($urandom_range(PREG_NUM - 1));
        u.rd_wen  = $urandom_range(1) != 0;
        if (u.op == LOAD) begin
            u.rd_wen = 1'b0;
            s = $urandom_range(PREG_NUM - 1);
            for (int i = 0; i < PREG_NUM; i++) begin
                k = (s + i) % PREG_NUM;
                if (!allocated[k] && readers[k] == 0 && k != u.prs_idx) begin
                    u.prd_idx = preg_idx_t'(k);
                    u.rd_wen  = 1'b1;
                    break;
                end
            end
        end
        u.has_memdep  = $urandom_range(3) == 0;
        u.dep_rob_idx = rob_idx_t'($urandom_range(ROB_SIZE - 1));
        u.bank        = bank_t'($urandom_range(BANK_NUM - 1));
        return u;
    endfunction

    task automatic commit_uop(input mem_uop_t u);
        out_q[u.rob_idx]    = 1'b1;
        exp_uop[u.rob_idx]  = u;
        dep_seen[u.rob_idx] = 1'b0;
        waits[u.rob_idx]    = allocated[u.prs_idx] && pending_ld[u.prs_idx];
        disp_cyc[u.rob_idx] = cycle;
        readers[u.prs_idx]++;
        if (u.op == LOAD && u.rd_wen) begin
            allocated[u.prd_idx]  = 1'b1;
            pending_ld[u.prd_idx] = 1'b1;
            ld_rob[u.prd_idx]     = u.rob_idx;
        end
        n_sent++;
        n_out++;
        next_rob++;
    endtask

    task automatic drive_inputs();
        int s;
        int k;
        disp_vld    = '0;
        store_issue = '0;
        ext_wb_vld  = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            if (n_sent < N_OPS && !out_q[next_rob] && $urandom_range(3) != 0) begin
                disp_uop[p] = build_uop();
                disp_vld[p] = 1'b1;
                // offered while not ready, the DUT must ignore it
                if (!disp_ready)
                    break;
                commit_uop(disp_uop[p]);
            end
        end
        if ($urandom_range(2) == 0) begin
            s = $urandom_range(ROB_SIZE - 1);
            for (int i = 0; i < ROB_SIZE; i++) begin
                k = (s + i) % ROB_SIZE;
                if (out_q[k] && exp_uop[k].has_memdep && disp_cyc[k] < cycle) begin
                    store_issue[0] = 1'b1;
                    store_rob[0]   = exp_uop[k].dep_rob_idx;
                    break;
                end
            end
        end
        if ($urandom_range(7) == 0) begin
            store_issue[1] = 1'b1;
            store_rob[1]   = rob_idx_t'($urandom_range(ROB_SIZE - 1));
        end
        for (int i = 0; i < ROB_SIZE; i++) begin
            if (out_q[i] && exp_uop[i].has_memdep && disp_cyc[i] < cycle) begin
                for (int j = 0; j < STORE_ISSUE_NUM; j++) begin
                    if (store_issue[j] && store_rob[j] == exp_uop[i].dep_rob_idx)
                        dep_seen[i] = 1'b1;
                end
            end
        end
        // other clusters only write registers nobody waits on
        for (int w = 0; w < EXT_WB_NUM; w++) begin
            k = $urandom_range(PREG_NUM - 1);
            if ($urandom_range(3) == 0 && !allocated[k]) begin
                ext_wb_vld[w] = 1'b1;
                ext_wb_prd[w] = preg_idx_t'(k);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6e5));
        rst         = 1'b1;
        disp_vld    = '0;
        ext_wb_vld  = '0;
        store_issue = '0;
        for (int p = 0; p < PORT_NUM; p++)
            disp_uop[p] = '0;
        for (int w = 0; w < EXT_WB_NUM; w++)
            ext_wb_prd[w] = '0;
        for (int s = 0; s < STORE_ISSUE_NUM; s++)
            store_rob[s] = '0;
        for (int i = 0; i < PREG_NUM; i++) begin
            allocated[i]  = 1'b0;
            pending_ld[i] = 1'b0;
            ld_rob[i]     = '0;
            readers[i]    = 0;
            last_wb[i]    = -1;
        end
        for (int i = 0; i < ROB_SIZE; i++)
            out_q[i] = 1'b0;
        cycle    = 0;
        n_sent   = 0;
        n_out    = 0;
        next_rob = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (n_sent < N_OPS || n_out > 0) begin
            @(negedge clk);
            cycle++;
            if (cycle > TIMEOUT) begin
                $display("** Error at %0t: timeout, %0d of %0d ops never completed",
                         $time, n_out, n_sent);
                $display("Test failed");
                $fatal(1, "timeout");
            end
            check_outputs();
            drive_inputs();
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- mem_issue_top.f
mem_issue_pkg.sv
mem_issue_if.sv
mem_dispatch_stage.sv
age_select.sv
mem_issue_queue.sv
mem_issue_pipe.sv
mem_issue_top.sv
mem_issue_props.sv
mem_issue_tb.sv

//--- Bender.yml
package:
  name: mem_issue

sources:
  - mem_issue_pkg.sv
  - mem_issue_if.sv
  - mem_dispatch_stage.sv
  - age_select.sv
  - mem_issue_queue.sv
  - mem_issue_pipe.sv
  - mem_issue_top.sv
  - target: test
    files:
      - mem_issue_props.sv
      - mem_issue_tb.sv
